// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = rs_unit_tb
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = FAIL: see errors above

SHELL := /bin/bash

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	set -o pipefail; ./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: bench/rs_unit_vectors.svh
`ifndef RS_UNIT_VECTORS_SVH
`define RS_UNIT_VECTORS_SVH

// One issued operation, its expected result and the CDB traffic around it.
// j and k hold a value when their ready bit is set, else the awaited tag in the low three bits.
// bc[0] is driven in the acceptance cycle, bc[1] to bc[3] on the cycles after it.
// Rows with rnd set draw both operands from the LFSR and the result comes from the model.
typedef struct packed
{
	lc3b_types::alu_op_t    op;
	logic                   rnd;
	logic                   j_ready;
	lc3b_types::lc3b_word   j;
	logic                   k_ready;
	lc3b_types::lc3b_word   k;
	lc3b_types::rs_tag      dest;
	lc3b_types::lc3b_word   exp;
	lc3b_types::cdb_t [0:3] bc;
} vec_t;

localparam lc3b_types::cdb_t NO_BC = '0;
localparam int NUM_VECTORS = 15;

localparam vec_t VECTORS [NUM_VECTORS] = '{
	'{lc3b_types::op_add,   1'b0, 1'b1, 16'h1234, 1'b1, 16'h0F0F, 3'd1, 16'h2143,
		{NO_BC, NO_BC, NO_BC, NO_BC}},
	'{lc3b_types::op_and,   1'b0, 1'b1, 16'hF0F0, 1'b1, 16'h3C3C, 3'd2, 16'h3030,
		{NO_BC, NO_BC, NO_BC, NO_BC}},
	'{lc3b_types::op_not,   1'b0, 1'b1, 16'h00FF, 1'b1, 16'h0000, 3'd3, 16'hFF00,
		{NO_BC, NO_BC, NO_BC, NO_BC}},
	// Only vk[3:0] counts as the shift amount.
	'{lc3b_types::op_lshf,  1'b0, 1'b1, 16'h0001, 1'b1, 16'h0013, 3'd4, 16'h0008,
		{NO_BC, NO_BC, NO_BC, NO_BC}},
	'{lc3b_types::op_rshfl, 1'b0, 1'b1, 16'h8000, 1'b1, 16'h0004, 3'd5, 16'h0800,
		{NO_BC, NO_BC, NO_BC, NO_BC}},
	'{lc3b_types::op_rshfa, 1'b0, 1'b1, 16'h8000, 1'b1, 16'h0004, 3'd6, 16'hF800,
		{NO_BC, NO_BC, NO_BC, NO_BC}},
	'{lc3b_types::op_rshfa, 1'b0, 1'b1, 16'h4000, 1'b1, 16'h0002, 3'd7, 16'h1000,
		{NO_BC, NO_BC, NO_BC, NO_BC}},
	'{lc3b_types::op_add,   1'b1, 1'b1, 16'h0000, 1'b1, 16'h0000, 3'd0, 16'h0000,
		{NO_BC, NO_BC, NO_BC, NO_BC}},
	'{lc3b_types::op_and,   1'b1, 1'b1, 16'h0000, 1'b1, 16'h0000, 3'd1, 16'h0000,
		{NO_BC, NO_BC, NO_BC, NO_BC}},
	'{lc3b_types::op_rshfa, 1'b1, 1'b1, 16'h0000, 1'b1, 16'h0000, 3'd2, 16'h0000,
		{NO_BC, NO_BC, NO_BC, NO_BC}},
	'{lc3b_types::op_lshf,  1'b1, 1'b1, 16'h0000, 1'b1, 16'h0000, 3'd3, 16'h0000,
		{NO_BC, NO_BC, NO_BC, NO_BC}},
	// vj arrives in the acceptance cycle, a repeat of tag 2 follows.
	'{lc3b_types::op_add,   1'b0, 1'b0, 16'h0002, 1'b1, 16'h0005, 3'd4, 16'h0105,
		{{1'b1, 3'd2, 16'h0100}, {1'b1, 3'd2, 16'h9999}, NO_BC, NO_BC}},
	// An invalid broadcast with the right tag and a wrong tag come first.
	'{lc3b_types::op_and,   1'b0, 1'b1, 16'hFF00, 1'b0, 16'h0006, 3'd5, 16'h0F00,
		{{1'b0, 3'd6, 16'hDEAD}, {1'b1, 3'd3, 16'h0F0F}, {1'b1, 3'd6, 16'h0FF0}, NO_BC}},
	'{lc3b_types::op_add,   1'b0, 1'b0, 16'h0001, 1'b0, 16'h0004, 3'd6, 16'h0230,
		{{1'b1, 3'd5, 16'h1111}, {1'b1, 3'd1, 16'h0200}, {1'b1, 3'd1, 16'h7777},
		{1'b1, 3'd4, 16'h0030}}},
	// Both operands wait on the same producer.
	'{lc3b_types::op_lshf,  1'b0, 1'b0, 16'h0003, 1'b0, 16'h0003, 3'd7, 16'h0380,
		{{1'b1, 3'd3, 16'h0007}, NO_BC, NO_BC, NO_BC}}
};

`endif

// File: bench/rs_unit_tb.sv
`default_nettype none

module rs_unit_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int POLL_LIMIT = 64;

	logic                  clk;
	logic                  rst_n;
	logic                  flush;
	lc3b_types::rs_issue_t issue;
	logic                  issue_valid;
	logic                  issue_ready;
	lc3b_types::cdb_t      cdb_in;
	lc3b_types::cdb_t      cdb_out;
	logic                  cdb_grant;

	int          errors;
	int          timeouts;
	logic [15:0] lfsr;

	// Expected result per destination tag, and the tags still owed a result.
	lc3b_types::lc3b_word expected [8];
	logic [7:0]           pending;

	`include "rs_unit_vectors.svh"

	rs_unit dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.flush       (flush),
		.issue       (issue),
		.issue_valid (issue_valid),
		.issue_ready (issue_ready),
		.cdb_in      (cdb_in),
		.cdb_out     (cdb_out),
		.cdb_grant   (cdb_grant)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Galois form of x^16 + x^14 + x^13 + x^11 + 1.
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic random_word(output lc3b_types::lc3b_word w);
		w = '0;
		for (int i = 0; i < 16; i++)
		begin
			lfsr = lfsr_next(lfsr);
			w    = {w[14:0], lfsr[0]};
		end
	endtask

	function automatic lc3b_types::lc3b_word alu_model(input lc3b_types::alu_op_t op,
		input lc3b_types::lc3b_word a, input lc3b_types::lc3b_word b);
		logic [31:0] ext;
		// Sign extend to twice the width so a logical shift copies the sign in.
		ext = {{16{a[15]}}, a} >> b[3:0];
		case (op)
			lc3b_types::op_add:   return a + b;
			lc3b_types::op_and:   return a & b;
			lc3b_types::op_not:   return ~a;
			lc3b_types::op_lshf:  return a << b[3:0];
			lc3b_types::op_rshfl: return a >> b[3:0];
			default:              return ext[15:0];
		endcase
	endfunction

	function automatic lc3b_types::rs_issue_t ready_op(input lc3b_types::alu_op_t op,
		input lc3b_types::lc3b_word a, input lc3b_types::lc3b_word b,
		input lc3b_types::rs_tag dest);
		lc3b_types::rs_issue_t r;
		r          = '0;
		r.op       = op;
		r.vj       = a;
		r.j_ready  = 1'b1;
		r.vk       = b;
		r.k_ready  = 1'b1;
		r.dest_tag = dest;
		return r;
	endfunction

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("** Error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic owe(input lc3b_types::rs_tag tag, input lc3b_types::lc3b_word value);
		expected[tag] = value;
		pending[tag]  = 1'b1;
	endtask

	task automatic wait_issue_ready(output logic ok);
		int n;
		n = 0;
		while (!issue_ready && n < POLL_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		ok = issue_ready;
		if (!ok)
		begin
			timeouts++;
			$display("Timeout: the station never had a free entry for a new operation");
		end
	endtask

	task automatic wait_result_valid(output logic ok);
		int n;
		n = 0;
		while (!cdb_out.valid && n < POLL_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		ok = cdb_out.valid;
		if (!ok)
		begin
			timeouts++;
			$display("Timeout: no result showed up on the CDB output");
		end
	endtask

	task automatic issue_op(input lc3b_types::rs_issue_t op, input lc3b_types::cdb_t bc);
		logic ok;
		wait_issue_ready(ok);
		if (ok)
		begin
			issue       = op;
			issue_valid = 1'b1;
			cdb_in      = bc;
			@(negedge clk);
			issue_valid = 1'b0;
			cdb_in      = '0;
		end
	endtask

	// Acts as the CDB arbiter for one result and matches it by tag.
	task automatic collect_result();
		logic ok;
		wait_result_valid(ok);
		if (ok)
		begin
			if (!pending[cdb_out.tag])
			begin
				errors++;
				$display("A result came out with tag %0d, which no live operation owns",
					cdb_out.tag);
			end
			else
				check_value("cdb_out.data", cdb_out.data, expected[cdb_out.tag]);
			pending[cdb_out.tag] = 1'b0;
			cdb_grant = 1'b1;
			@(negedge clk);
			cdb_grant = 1'b0;
		end
	endtask

	task automatic apply_vector(input vec_t v);
		lc3b_types::rs_issue_t op;
		lc3b_types::lc3b_word  a;
		lc3b_types::lc3b_word  b;
		a = v.j;
		b = v.k;
		if (v.rnd)
		begin
			random_word(a);
			random_word(b);
		end
		op          = ready_op(v.op, a, b, v.dest);
		op.j_ready  = v.j_ready;
		op.qj       = v.j[2:0];
		op.k_ready  = v.k_ready;
		op.qk       = v.k[2:0];
		owe(v.dest, v.rnd ? alu_model(v.op, a, b) : v.exp);
		issue_op(op, v.bc[0]);
		for (int i = 1; i < 4; i++)
		begin
			cdb_in = v.bc[i];
			@(negedge clk);
		end
		cdb_in = '0;
		collect_result();
	endtask

	task automatic back_pressure_case();
		logic ok;
		owe(3'd3, 16'h0303);
		issue_op(ready_op(lc3b_types::op_add, 16'h0101, 16'h0202, 3'd3), '0);
		wait_result_valid(ok);
		// Two more operations fill both entries behind the stalled result.
		owe(3'd4, 16'h0F00);
		issue_op(ready_op(lc3b_types::op_and, 16'hFF0F, 16'h0FF0, 3'd4), '0);
		owe(3'd5, 16'hEDCB);
		issue_op(ready_op(lc3b_types::op_not, 16'h1234, 16'h0000, 3'd5), '0);
		repeat (4)
		begin
			check_value("issue_ready", 16'(issue_ready), 16'd0);
			check_value("cdb_out.valid", 16'(cdb_out.valid), 16'd1);
			check_value("cdb_out.tag", 16'(cdb_out.tag), 16'd3);
			check_value("cdb_out.data", cdb_out.data, 16'h0303);
			@(negedge clk);
		end
		collect_result();
		wait_issue_ready(ok);
		collect_result();
		collect_result();
	endtask

	task automatic flush_case();
		logic ok;
		issue_op(ready_op(lc3b_types::op_add, 16'h1111, 16'h2222, 3'd6), '0);
		wait_result_valid(ok);
		issue_op(ready_op(lc3b_types::op_and, 16'hAAAA, 16'h0F0F, 3'd1), '0);
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		// A granting arbiter would now take anything the flush left behind.
		cdb_grant = 1'b1;
		repeat (8)
		begin
			check_value("cdb_out.valid", 16'(cdb_out.valid), 16'd0);
			@(negedge clk);
		end
		cdb_grant = 1'b0;
		check_value("issue_ready", 16'(issue_ready), 16'd1);
		owe(3'd2, 16'h00F0);
		issue_op(ready_op(lc3b_types::op_rshfl, 16'hF000, 16'h0008, 3'd2), '0);
		collect_result();
	endtask

	initial
	begin
		errors      = 0;
		timeouts    = 0;
		lfsr        = 16'd27;
		pending     = '0;
		rst_n       = 1'b0;
		flush       = 1'b0;
		issue       = '0;
		issue_valid = 1'b0;
		cdb_in      = '0;
		cdb_grant   = 1'b0;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_value("issue_ready", 16'(issue_ready), 16'd1);
		check_value("cdb_out.valid", 16'(cdb_out.valid), 16'd0);
		check_value("exec_done", 16'(dut.exec_done), 16'd0);
		for (int i = 0; i < NUM_VECTORS; i++)
			apply_vector(VECTORS[i]);
		back_pressure_case();
		flush_case();
		$display("Vectors applied: %0d, mismatches: %0d, timeouts: %0d",
			NUM_VECTORS, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/exec_timer.sv
`default_nettype none

module exec_timer (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             flush,
	input  logic                             start,
	input  logic [lc3b_types::LAT_WIDTH-1:0] latency,
	output logic                             done
);

	// Cycles left for the running operation, zero when idle.
	logic [lc3b_types::LAT_WIDTH-1:0] count;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			count <= '0;
		else if (flush)
			count <= '0;
		else if (start)
			count <= latency;
		else if (count != '0)
			count <= count - 1'b1;
	end

	// Last cycle of the count.
	assign done = (count == 1);

	// One operation at a time, the FSM waits for done before the next start.
	a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> (count == '0));

endmodule

`default_nettype wire

// File: source/lc3b_alu.sv
`default_nettype none

module lc3b_alu (
	input  lc3b_types::rs_slot_t slot,
	output lc3b_types::lc3b_word result
);

	logic [3:0] shamt;

	assign shamt = slot.vk[3:0];

	always_comb
	begin
		case (slot.op)
			lc3b_types::op_add:   result = slot.vj + slot.vk;
			lc3b_types::op_and:   result = slot.vj & slot.vk;
			lc3b_types::op_not:   result = ~slot.vj;
			lc3b_types::op_lshf:  result = slot.vj << shamt;
			lc3b_types::op_rshfl: result = slot.vj >> shamt;
			// Sign bit fills from the left.
			lc3b_types::op_rshfa: result = $signed(slot.vj) >>> shamt;
			default:              result = slot.vj;
		endcase
	end

endmodule

`default_nettype wire

// File: source/lc3b_types.sv
`default_nettype none

package lc3b_types;

	// Data and tag widths.
	typedef logic [15:0] lc3b_word;
	typedef logic [2:0]  rs_tag;

	// ALU operations. Shifts take their amount from vk[3:0].
	typedef enum logic [2:0]
	{
		op_add,
		op_and,
		op_not,
		op_lshf,
		op_rshfl,
		op_rshfa
	} alu_op_t;

	// One broadcast on the common data bus.
	typedef struct packed
	{
		logic     valid;
		rs_tag    tag;
		lc3b_word data;
	} cdb_t;

	// Operation as it leaves the issue stage.
	// A operand with its ready bit low is named by its producer tag.
	typedef struct packed
	{
		alu_op_t  op;
		lc3b_word vj;
		logic     j_ready;
		rs_tag    qj;
		lc3b_word vk;
		logic     k_ready;
		rs_tag    qk;
		rs_tag    dest_tag;
	} rs_issue_t;

	// Contents of one ready entry, as seen by the ALU.
	typedef struct packed
	{
		alu_op_t  op;
		lc3b_word vj;
		lc3b_word vk;
		rs_tag    dest_tag;
	} rs_slot_t;

	typedef enum logic [1:0]
	{
		st_idle,
		st_exec,
		st_broadcast
	} issue_state_t;

	localparam int NUM_RS_ENTRIES = 2;

	// Execution latencies, in cycles.
	localparam int LAT_WIDTH = 2;
	localparam logic [LAT_WIDTH-1:0] LAT_LOGIC = LAT_WIDTH'(1);
	localparam logic [LAT_WIDTH-1:0] LAT_SHIFT = LAT_WIDTH'(3);

endpackage

`default_nettype wire

// File: source/rs_entry.sv
`default_nettype none

module rs_entry (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 flush,
	input  logic                 load,
	input  lc3b_types::rs_issue_t issue,
	input  lc3b_types::cdb_t     cdb_in,
	input  logic                 dispatch,
	output logic                 busy,
	output logic                 ready,
	output lc3b_types::rs_slot_t slot
);

	// Control state.
	logic j_wait;
	logic k_wait;

	// Held operation.
	lc3b_types::alu_op_t  op;
	lc3b_types::lc3b_word vj;
	lc3b_types::lc3b_word vk;
	lc3b_types::rs_tag    qj;
	lc3b_types::rs_tag    qk;
	lc3b_types::rs_tag    dest_tag;

	// CDB matches for the incoming operation.
	logic j_load_hit;
	logic k_load_hit;

	// CDB matches for the held operation.
	logic j_hit;
	logic k_hit;

	assign j_load_hit = cdb_in.valid && !issue.j_ready && (cdb_in.tag == issue.qj);
	assign k_load_hit = cdb_in.valid && !issue.k_ready && (cdb_in.tag == issue.qk);

	// Only a waiting operand listens, so a captured value is never overwritten.
	assign j_hit = busy && j_wait && cdb_in.valid && (cdb_in.tag == qj);
	assign k_hit = busy && k_wait && cdb_in.valid && (cdb_in.tag == qk);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy   <= 1'b0;
			j_wait <= 1'b0;
			k_wait <= 1'b0;
		end
		else if (flush)
		begin
			busy   <= 1'b0;
			j_wait <= 1'b0;
			k_wait <= 1'b0;
		end
		else if (load)
		begin
			busy   <= 1'b1;
			j_wait <= !issue.j_ready && !j_load_hit;
			k_wait <= !issue.k_ready && !k_load_hit;
		end
		else
		begin
			if (dispatch)
				busy <= 1'b0;
			if (j_hit)
				j_wait <= 1'b0;
			if (k_hit)
				k_wait <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			op       <= issue.op;
			dest_tag <= issue.dest_tag;
			qj       <= issue.qj;
			qk       <= issue.qk;
			// Bus data is only kept when the wait flag clears with it.
			vj       <= issue.j_ready ? issue.vj : cdb_in.data;
			vk       <= issue.k_ready ? issue.vk : cdb_in.data;
		end
		else
		begin
			if (j_hit)
				vj <= cdb_in.data;
			if (k_hit)
				vk <= cdb_in.data;
		end
	end

	assign ready = busy && !j_wait && !k_wait;

	assign slot.op       = op;
	assign slot.vj       = vj;
	assign slot.vk       = vk;
	assign slot.dest_tag = dest_tag;

	// Captured operands ignore later broadcasts until a new load.
	a_operand_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(busy && !j_wait && !k_wait && !load) |=> ($stable(vj) && $stable(vk)));

endmodule

`default_nettype wire

// File: source/rs_issue_fsm.sv
`default_nettype none

module rs_issue_fsm (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  flush,
	input  logic [lc3b_types::NUM_RS_ENTRIES-1:0] entry_ready,
	input  lc3b_types::rs_slot_t                  entry_slot [lc3b_types::NUM_RS_ENTRIES],
	output logic [lc3b_types::NUM_RS_ENTRIES-1:0] dispatch,
	output logic                                  exec_start,
	output logic [lc3b_types::LAT_WIDTH-1:0]      exec_latency,
	input  logic                                  exec_done,
	output lc3b_types::rs_slot_t                  alu_slot,
	input  lc3b_types::lc3b_word                  alu_result,
	input  logic                                  cdb_grant,
	output lc3b_types::cdb_t                      cdb_out
);

	lc3b_types::issue_state_t state;

	logic [lc3b_types::NUM_RS_ENTRIES-1:0] pick;
	lc3b_types::rs_slot_t                  pick_slot;

	// Result register.
	logic                 out_valid;
	lc3b_types::rs_tag    out_tag;
	lc3b_types::lc3b_word out_data;

	// Two's complement isolates the lowest ready entry.
	assign pick = entry_ready & -entry_ready;

	always_comb
	begin
		pick_slot = '0;
		for (int i = 0; i < lc3b_types::NUM_RS_ENTRIES; i++)
		begin
			if (pick[i])
				pick_slot = entry_slot[i];
		end
	end

	// Shifts run longer than the logic and add operations.
	always_comb
	begin
		case (pick_slot.op)
			lc3b_types::op_lshf,
			lc3b_types::op_rshfl,
			lc3b_types::op_rshfa: exec_latency = lc3b_types::LAT_SHIFT;
			default:              exec_latency = lc3b_types::LAT_LOGIC;
		endcase
	end

	assign exec_start = (state == lc3b_types::st_idle) && (|entry_ready);
	assign dispatch   = (state == lc3b_types::st_idle) ? pick : '0;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= lc3b_types::st_idle;
			out_valid <= 1'b0;
		end
		else if (flush)
		begin
			state     <= lc3b_types::st_idle;
			out_valid <= 1'b0;
		end
		else
		begin
			case (state)
				lc3b_types::st_idle:
				begin
					if (|entry_ready)
						state <= lc3b_types::st_exec;
				end
				lc3b_types::st_exec:
				begin
					if (exec_done)
					begin
						state     <= lc3b_types::st_broadcast;
						out_valid <= 1'b1;
					end
				end
				lc3b_types::st_broadcast:
				begin
					// Hold the bus until the arbiter takes the result.
					if (cdb_grant)
					begin
						state     <= lc3b_types::st_idle;
						out_valid <= 1'b0;
					end
				end
				default: state <= lc3b_types::st_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (exec_start)
			alu_slot <= pick_slot;
		if ((state == lc3b_types::st_exec) && exec_done)
		begin
			out_tag  <= alu_slot.dest_tag;
			out_data <= alu_result;
		end
	end

	assign cdb_out.valid = out_valid;
	assign cdb_out.tag   = out_tag;
	assign cdb_out.data  = out_data;

	// An ungranted result may not change under the arbiter.
	a_cdb_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(cdb_out.valid && !cdb_grant && !flush) |=> $stable(cdb_out));

endmodule

`default_nettype wire

// File: source/rs_unit.sv
`default_nettype none

module rs_unit (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  flush,
	input  lc3b_types::rs_issue_t issue,
	input  logic                  issue_valid,
	output logic                  issue_ready,
	input  lc3b_types::cdb_t      cdb_in,
	output lc3b_types::cdb_t      cdb_out,
	input  logic                  cdb_grant
);

	logic [lc3b_types::NUM_RS_ENTRIES-1:0] busy;
	logic [lc3b_types::NUM_RS_ENTRIES-1:0] free;
	logic [lc3b_types::NUM_RS_ENTRIES-1:0] load;
	logic [lc3b_types::NUM_RS_ENTRIES-1:0] entry_ready;
	logic [lc3b_types::NUM_RS_ENTRIES-1:0] dispatch;

	lc3b_types::rs_slot_t entry_slot [lc3b_types::NUM_RS_ENTRIES];

	logic                             exec_start;
	logic [lc3b_types::LAT_WIDTH-1:0] exec_latency;
	logic                             exec_done;

	lc3b_types::rs_slot_t alu_slot;
	lc3b_types::lc3b_word alu_result;

	assign free        = ~busy;
	assign issue_ready = |free;

	// New operations go into the lowest free entry.
	assign load = issue_valid ? (free & -free) : '0;

	for (genvar i = 0; i < lc3b_types::NUM_RS_ENTRIES; i++)
	begin : g_entry
		rs_entry u_entry (
			.clk      (clk),
			.rst_n    (rst_n),
			.flush    (flush),
			.load     (load[i]),
			.issue    (issue),
			.cdb_in   (cdb_in),
			.dispatch (dispatch[i]),
			.busy     (busy[i]),
			.ready    (entry_ready[i]),
			.slot     (entry_slot[i])
		);
	end

	rs_issue_fsm u_fsm (
		.clk          (clk),
		.rst_n        (rst_n),
		.flush        (flush),
		.entry_ready  (entry_ready),
		.entry_slot   (entry_slot),
		.dispatch     (dispatch),
		.exec_start   (exec_start),
		.exec_latency (exec_latency),
		.exec_done    (exec_done),
		.alu_slot     (alu_slot),
		.alu_result   (alu_result),
		.cdb_grant    (cdb_grant),
		.cdb_out      (cdb_out)
	);

	exec_timer u_timer (
		.clk     (clk),
		.rst_n   (rst_n),
		.flush   (flush),
		.start   (exec_start),
		.latency (exec_latency),
		.done    (exec_done)
	);

	lc3b_alu u_alu (
		.slot   (alu_slot),
		.result (alu_result)
	);

endmodule

`default_nettype wire

// File: verilog.f
+incdir+bench
source/lc3b_types.sv
source/exec_timer.sv
source/lc3b_alu.sv
source/rs_entry.sv
source/rs_issue_fsm.sv
source/rs_unit.sv
bench/rs_unit_tb.sv
